// File: Bender.yml
package:
  name: lc3b_cache

export_include_dirs:
  - hdl

sources:
  - hdl/lc3b_types_pkg.sv
  - hdl/cache_ctrl_if.sv
  - hdl/byte_insert.sv
  - hdl/set_sweep_counter.sv
  - hdl/cache_control.sv
  - hdl/cache_datapath.sv
  - hdl/lc3b_cache.sv
  - target: test
    files:
      - bench/lc3b_cache_assert.sv
      - bench/lc3b_cache_tb.sv

// File: bench/lc3b_cache_assert.sv
`timescale 1ns/1ps

`default_nettype none

module lc3b_cache_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic mem_resp,
	input wire logic pmem_read,
	input wire logic pmem_write,
	input wire logic pmem_resp,
	input wire logic [11:0] pmem_address,
	input wire logic [127:0] pmem_wdata
	);

int unsigned fail_count = 0;
logic [3:0] init_cycles; // Cycles since reset release, saturates at 8.

always_ff @(posedge clk) begin
	if (!rst_n) begin
		init_cycles <= '0;
	end else if (init_cycles != 4'd8) begin
		init_cycles <= init_cycles + 1'b1;
	end
end

resp_single: assert property (@(posedge clk) disable iff (!rst_n)
	mem_resp |=> !mem_resp) else begin
	$error("mem_resp high for two cycles");
	fail_count++;
end

strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
	!(pmem_read && pmem_write)) else begin
	$error("pmem_read and pmem_write high together");
	fail_count++;
end

// Address, and write data on a write, held until the memory answers.
pmem_stable: assert property (@(posedge clk) disable iff (!rst_n)
	(pmem_read || pmem_write) && !pmem_resp |=>
	$stable(pmem_address) && (!pmem_write || $stable(pmem_wdata))) else begin
	$error("pmem request changed before pmem_resp");
	fail_count++;
end

init_quiet: assert property (@(posedge clk) disable iff (!rst_n)
	init_cycles != 4'd8 |-> !pmem_read && !pmem_write && !mem_resp) else begin
	$error("strobe or response during the init sweep");
	fail_count++;
end

endmodule : lc3b_cache_assert

bind lc3b_cache lc3b_cache_assert assertions (
	.clk(clk),
	.rst_n(rst_n),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata)
);

`default_nettype wire

// File: bench/lc3b_cache_tb.sv
`timescale 1ns/1ps

`default_nettype none

module lc3b_cache_tb;

localparam int CLK_HALF = 20;
localparam int DRIVE_DELAY = 2;
localparam int RESET_CYCLES = 8;
localparam int INIT_CYCLES = 8;
localparam int RESP_TIMEOUT = 200;
localparam logic RD = 1'b0;
localparam logic WR = 1'b1;
localparam logic [1:0] ANY = 2'd0;
localparam logic [1:0] HIT = 2'd1;  // Response on the second edge.
localparam logic [1:0] COLD = 2'd2; // Raised while the sweep runs.
// Line 0x001 after all byte stores, slot 7 leftmost.
localparam logic [127:0] EVICT_LINE = {16'h88CC, 16'h5A77, 16'h6666, 16'h5542,
	16'h5A44, 16'h3333, 16'h2248, 16'h5A11};

typedef struct packed {
	logic op;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic [1:0] mask;
	logic [15:0] exp_data;
	logic [1:0] timing;
	logic wb;
	logic [11:0] wb_addr;
	logic [127:0] wb_line;
} row_t;

logic clk, rst_n;
logic mem_read, mem_write, mem_resp;
logic [15:0] mem_address, mem_wdata, mem_rdata;
logic [1:0] mem_byte_enable;
logic pmem_read, pmem_write, pmem_resp;
logic [11:0] pmem_address;
logic [127:0] pmem_wdata, pmem_rdata;

logic [127:0] mem [4096];
logic [15:0] lfsr_state;
logic [11:0] wb_addr_q [$];
logic [127:0] wb_data_q [$];
row_t rows [$];

lc3b_cache DUT (.*);

initial begin
	clk = 1'b0;
	forever begin
		#CLK_HALF clk = ~clk;
	end
end

function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
endfunction

task automatic draw_bits(input int count, output int value);
	int i;
	value = 0;
	for (i = 0; i < count; i++) begin
		value = (value << 1) | lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

task automatic check_value(input string what, input logic [127:0] actual,
	input logic [127:0] expected);
	if (actual !== expected) begin
		$display("FAIL %0t ns: %s: expected %0h, got %0h", $time, what, expected, actual);
		$display("*** FAILED ***");
		$fatal(1);
	end
endtask

task automatic add_row(input logic op, input logic [15:0] addr, input logic [15:0] wdata,
	input logic [1:0] mask, input logic [15:0] exp_data, input logic [1:0] timing,
	input logic wb, input logic [11:0] wb_addr, input logic [127:0] wb_line);
	rows.push_back('{op, addr, wdata, mask, exp_data, timing, wb, wb_addr, wb_line});
endtask

initial begin : memory_model
	int line;
	int slot;
	int delay;
	logic [11:0] line_addr;
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	lfsr_state = 16'd6136;
	for (line = 0; line < 4096; line++) begin
		for (slot = 0; slot < 8; slot++) begin
			mem[line][slot*16 +: 16] = {line[11:0], slot[2:0], 1'b0} ^ 16'h5A5A;
		end
	end
	forever begin
		@(negedge clk);
		if (rst_n === 1'b1 && (pmem_read || pmem_write)) begin
			line_addr = pmem_address;
			if (pmem_write) begin
				mem[line_addr] = pmem_wdata;
				wb_addr_q.push_back(line_addr); // Logged for the row checks.
				wb_data_q.push_back(pmem_wdata);
			end
			draw_bits(3, delay);
			repeat (delay + 1) @(posedge clk);
			#DRIVE_DELAY;
			pmem_rdata = mem[line_addr];
			pmem_resp = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			pmem_resp = 1'b0;
		end
	end
end

initial begin : stimulus
	int row;
	int edges;
	int wb_before;
	row_t r;
	rst_n = 1'b0;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_address = '0;
	mem_wdata = '0;
	mem_byte_enable = '0;
	add_row(RD, 16'h0012, 16'h0000, 2'b00, 16'h5A48, COLD, 1'b0, 12'h000, '0);
	add_row(RD, 16'h0012, 16'h0000, 2'b00, 16'h5A48, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h1234, 16'h0000, 2'b00, 16'h486E, ANY, 1'b0, 12'h000, '0);
	add_row(RD, 16'h123E, 16'h0000, 2'b00, 16'h4864, HIT, 1'b0, 12'h000, '0);
	// Byte stores over every slot of line 0x001.
	add_row(WR, 16'h0010, 16'h1111, 2'b01, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h0012, 16'h2222, 2'b10, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h0014, 16'h3333, 2'b11, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h0016, 16'h4444, 2'b01, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h0018, 16'h5555, 2'b10, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h001A, 16'h6666, 2'b11, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h001C, 16'h7777, 2'b01, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h001E, 16'h8888, 2'b10, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(WR, 16'h001E, 16'h99CC, 2'b01, 16'h0000, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h0010, 16'h0000, 2'b00, 16'h5A11, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h0012, 16'h0000, 2'b00, 16'h2248, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h0014, 16'h0000, 2'b00, 16'h3333, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h001E, 16'h0000, 2'b00, 16'h88CC, HIT, 1'b0, 12'h000, '0);
	// Conflict on set 1, then clean evictions.
	add_row(RD, 16'h0092, 16'h0000, 2'b00, 16'h5AC8, ANY, 1'b1, 12'h001, EVICT_LINE);
	add_row(RD, 16'h001E, 16'h0000, 2'b00, 16'h88CC, ANY, 1'b0, 12'h000, '0);
	add_row(RD, 16'h1234, 16'h0000, 2'b00, 16'h486E, HIT, 1'b0, 12'h000, '0);
	add_row(RD, 16'h23B0, 16'h0000, 2'b00, 16'h79EA, ANY, 1'b0, 12'h000, '0);
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DELAY;
	rst_n = 1'b1;
	for (row = 0; row < rows.size(); row++) begin
		r = rows[row];
		wb_before = wb_addr_q.size();
		@(posedge clk);
		#DRIVE_DELAY;
		mem_read = (r.op == RD);
		mem_write = (r.op == WR);
		mem_address = r.addr;
		mem_wdata = r.wdata;
		mem_byte_enable = r.mask;
		edges = 0;
		do begin
			@(negedge clk);
			edges++;
		end while (!mem_resp && edges < RESP_TIMEOUT);
		if (!mem_resp) begin
			$display("Timeout: no mem_resp for table row %0d.", row);
			$display("*** FAILED ***");
			$fatal(1);
		end
		if (r.op == RD) begin
			check_value("read data", mem_rdata, r.exp_data);
		end
		if (r.timing == HIT) begin
			check_value("hit latency in edges", edges, 2);
		end else if (r.timing == COLD) begin
			check_value("served after init sweep", edges > INIT_CYCLES, 1);
		end
		check_value("write-back count", wb_addr_q.size() - wb_before, r.wb);
		if (r.wb) begin
			check_value("write-back line address", wb_addr_q[wb_before], r.wb_addr);
			check_value("write-back line data", wb_data_q[wb_before], r.wb_line);
		end
	end
	@(posedge clk);
	#DRIVE_DELAY;
	mem_read = 1'b0;
	mem_write = 1'b0;
	repeat (4) @(posedge clk);
	check_value("assertion failures", DUT.assertions.fail_count, 0);
	$display("*** PASSED ***");
	$finish;
end

endmodule : lc3b_cache_tb

`default_nettype wire

// File: hdl/byte_insert.sv
`timescale 1ns/1ps

`include "cache_defs.svh"

`default_nettype none

module byte_insert import lc3b_types::*; (
	input wire lc3b_cache_offset sel_index,
	input wire lc3b_word write_data,
	input wire lc3b_pmem_line input_data,
	input wire lc3b_mem_wmask mem_byte_enable,
	output lc3b_pmem_line output_data
	);

logic [6:0] lo_pos;
logic [6:0] hi_pos;

// Bit positions of the two bytes in the addressed word slot.
assign lo_pos = {sel_index[3:1], 4'h0};
assign hi_pos = {sel_index[3:1], 4'h8};

always_comb begin
	output_data = input_data;

	if (mem_byte_enable[0]) begin
		output_data[lo_pos +: 8] = write_data[7:0];
	end

	if (mem_byte_enable[1]) begin
		output_data[hi_pos +: 8] = write_data[`WORD_BITS-1:8];
	end
end

endmodule : byte_insert

`default_nettype wire

// File: hdl/cache_control.sv
`timescale 1ns/1ps

`default_nettype none

module cache_control import lc3b_types::*; (
	input wire logic clk,
	input wire logic rst_n,
	cache_ctrl_if.control ctrl,
	input wire logic mem_read,
	input wire logic mem_write,
	input wire logic pmem_resp,
	input wire logic sweep_last,
	output logic sweep_start,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
	);

cache_state_t state;
cache_state_t next_state;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= INIT;
	end else begin
		state <= next_state;
	end
end

always_comb begin
	next_state = state;

	ctrl.load_data = 1'b0;
	ctrl.load_tag = 1'b0;
	ctrl.set_dirty = 1'b0;
	ctrl.clear_dirty = 1'b0;
	ctrl.fill_select = 1'b0;
	ctrl.wb_select = 1'b0;
	ctrl.sweep_en = 1'b0;

	sweep_start = 1'b0;
	mem_resp = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;

	case (state)
		INIT: begin
			// One set invalidated per cycle.
			sweep_start = 1'b1;
			ctrl.sweep_en = 1'b1;
			if (sweep_last) begin
				next_state = IDLE;
			end
		end

		IDLE: begin
			if (mem_read || mem_write) begin
				if (ctrl.hit) begin
					next_state = RESPOND;
					if (mem_write) begin
						ctrl.load_data = 1'b1; // Store merge into the line.
						ctrl.set_dirty = 1'b1;
					end
				end else if (ctrl.dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = FILL;
				end
			end
		end

		WRITEBACK: begin
			pmem_write = 1'b1;
			ctrl.wb_select = 1'b1; // Old tag goes out with the victim.
			if (pmem_resp) begin
				next_state = FILL;
			end
		end

		FILL: begin
			pmem_read = 1'b1;
			ctrl.fill_select = 1'b1;
			if (pmem_resp) begin
				ctrl.load_data = 1'b1;
				ctrl.load_tag = 1'b1;
				ctrl.clear_dirty = 1'b1;
				next_state = IDLE; // Hits on the second look.
			end
		end

		RESPOND: begin
			mem_resp = 1'b1;
			next_state = IDLE;
		end

		default: begin
			next_state = INIT;
		end
	endcase
end

endmodule : cache_control

`default_nettype wire

// File: hdl/cache_ctrl_if.sv
`timescale 1ns/1ps

`default_nettype none

interface cache_ctrl_if import lc3b_types::*; ();

	logic load_data;   // Write the selected line into the data array.
	logic load_tag;    // Write tag and set valid.
	logic set_dirty;
	logic clear_dirty;
	logic fill_select; // Line source is memory, not the store merge.
	logic wb_select;   // Memory address from the stored tag.
	logic sweep_en;

	logic hit;
	logic dirty;

	lc3b_cache_index sweep_index;

	modport control (
		output load_data, load_tag, set_dirty, clear_dirty,
		output fill_select, wb_select, sweep_en,
		input hit, dirty
	);

	modport datapath (
		input load_data, load_tag, set_dirty, clear_dirty,
		input fill_select, wb_select, sweep_en, sweep_index,
		output hit, dirty
	);

	modport sweep (output sweep_index);

endinterface : cache_ctrl_if

`default_nettype wire

// File: hdl/cache_datapath.sv
`timescale 1ns/1ps

`include "cache_defs.svh"

`default_nettype none

module cache_datapath import lc3b_types::*; (
	input wire logic clk,
	cache_ctrl_if.datapath ctrl,
	input wire lc3b_word mem_address,
	input wire lc3b_word mem_wdata,
	input wire lc3b_mem_wmask mem_byte_enable,
	input wire lc3b_pmem_line pmem_rdata,
	output lc3b_word mem_rdata,
	output lc3b_pmem_addr pmem_address,
	output lc3b_pmem_line pmem_wdata
	);

lc3b_pmem_line data_array [`CACHE_SETS];
lc3b_cache_tag tag_array [`CACHE_SETS];
logic valid_array [`CACHE_SETS];
logic dirty_array [`CACHE_SETS];

lc3b_cache_tag req_tag;
lc3b_cache_index index;
lc3b_cache_offset offset;

lc3b_pmem_line line_out;
lc3b_pmem_line merged_line;
lc3b_pmem_line line_in;
lc3b_cache_tag stored_tag;

assign offset = mem_address[`CACHE_OFFSET_BITS-1:0];
assign index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
assign req_tag = mem_address[`WORD_BITS-1 -: `CACHE_TAG_BITS];

assign line_out = data_array[index];
assign stored_tag = tag_array[index];

byte_insert merge (
	.sel_index(offset),
	.write_data(mem_wdata),
	.input_data(line_out),
	.mem_byte_enable(mem_byte_enable),
	.output_data(merged_line)
);

assign line_in = ctrl.fill_select ? pmem_rdata : merged_line;

always_ff @(posedge clk) begin
	if (ctrl.sweep_en) begin
		valid_array[ctrl.sweep_index] <= 1'b0;
		dirty_array[ctrl.sweep_index] <= 1'b0;
	end else begin
		if (ctrl.load_data) begin
			data_array[index] <= line_in;
		end
		if (ctrl.load_tag) begin
			tag_array[index] <= req_tag;
			valid_array[index] <= 1'b1;
		end
		if (ctrl.set_dirty) begin
			dirty_array[index] <= 1'b1;
		end else if (ctrl.clear_dirty) begin
			dirty_array[index] <= 1'b0;
		end
	end
end

assign ctrl.hit = valid_array[index] && (stored_tag == req_tag);
assign ctrl.dirty = valid_array[index] && dirty_array[index]; // Victim needs write-back.

// Word slot picked by offset bits 3 to 1.
assign mem_rdata = line_out[{offset[3:1], 4'h0} +: `WORD_BITS];

assign pmem_address = ctrl.wb_select ? {stored_tag, index} : {req_tag, index};
assign pmem_wdata = line_out;

endmodule : cache_datapath

`default_nettype wire

// File: hdl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`default_nettype none

// Direct-mapped, eight sets of 16-byte lines.
`define CACHE_SETS 8
`define CACHE_INDEX_BITS 3
`define CACHE_OFFSET_BITS 4
`define CACHE_TAG_BITS 9

`define LINE_BITS 128
`define WORD_BITS 16

`default_nettype wire

`endif

// File: hdl/lc3b_cache.sv
`timescale 1ns/1ps

`default_nettype none

module lc3b_cache import lc3b_types::*; (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic mem_read,
	input wire logic mem_write,
	input wire lc3b_word mem_address,
	input wire lc3b_word mem_wdata,
	input wire lc3b_mem_wmask mem_byte_enable,
	output lc3b_word mem_rdata,
	output logic mem_resp,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_pmem_addr pmem_address,
	output lc3b_pmem_line pmem_wdata,
	input wire lc3b_pmem_line pmem_rdata,
	input wire logic pmem_resp
	);

logic sweep_start;
logic sweep_last;

cache_ctrl_if ctrl ();

cache_control control (
	.clk(clk),
	.rst_n(rst_n),
	.ctrl(ctrl.control),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.pmem_resp(pmem_resp),
	.sweep_last(sweep_last),
	.sweep_start(sweep_start),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write)
);

set_sweep_counter sweep_counter (
	.clk(clk),
	.rst_n(rst_n),
	.sweep_start(sweep_start),
	.sweep(ctrl.sweep),
	.sweep_last(sweep_last)
);

cache_datapath datapath (
	.clk(clk),
	.ctrl(ctrl.datapath),
	.mem_address(mem_address),
	.mem_wdata(mem_wdata),
	.mem_byte_enable(mem_byte_enable),
	.pmem_rdata(pmem_rdata),
	.mem_rdata(mem_rdata),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata)
);

endmodule : lc3b_cache

`default_nettype wire

// File: hdl/lc3b_types_pkg.sv
`include "cache_defs.svh"

`default_nettype none

package lc3b_types;

	typedef logic [`WORD_BITS-1:0] lc3b_word; // Data word or byte address.
	typedef logic [`LINE_BITS-1:0] lc3b_pmem_line;

	typedef logic [`CACHE_OFFSET_BITS-1:0] lc3b_cache_offset;
	typedef logic [`CACHE_INDEX_BITS-1:0] lc3b_cache_index;
	typedef logic [`CACHE_TAG_BITS-1:0] lc3b_cache_tag;

	typedef logic [1:0] lc3b_mem_wmask; // Bit 1 high byte, bit 0 low byte.

	// Line address, tag above index.
	typedef logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] lc3b_pmem_addr;

	typedef enum logic [2:0] {
		INIT,
		IDLE,
		WRITEBACK,
		FILL,
		RESPOND
	} cache_state_t;

endpackage : lc3b_types

`default_nettype wire

// File: hdl/set_sweep_counter.sv
`timescale 1ns/1ps

`include "cache_defs.svh"

`default_nettype none

module set_sweep_counter import lc3b_types::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic sweep_start,
	cache_ctrl_if.sweep sweep,
	output logic sweep_last
	);

lc3b_cache_index count;

// Wraps back to set 0 after the last set and stays there.
always_ff @(posedge clk) begin
	if (!rst_n) begin
		count <= '0;
	end else if (sweep_start) begin
		count <= count + 1'b1;
	end
end

assign sweep.sweep_index = count;
assign sweep_last = (count == lc3b_cache_index'(`CACHE_SETS - 1)); // Set 7.

endmodule : set_sweep_counter

`default_nettype wire

// File: lc3b_cache.f
+incdir+hdl
hdl/lc3b_types_pkg.sv
hdl/cache_ctrl_if.sv
hdl/byte_insert.sv
hdl/set_sweep_counter.sv
hdl/cache_control.sv
hdl/cache_datapath.sv
hdl/lc3b_cache.sv
bench/lc3b_cache_assert.sv
bench/lc3b_cache_tb.sv
